/* flist.f */
src/tft_spi_pkg.sv
src/tft_write_buffer.sv
src/spi_frame_serializer.sv
src/tft_pin_driver.sv
src/tft_spi_top.sv
testbench/tb_spi_capture.sv
testbench/tb_tft_spi_top.sv

/* src/spi_frame_serializer.sv */
/*
 * Frame serializer FSM. Copies a pending address/data pair, interleaves
 * it into four address/data frames and shifts each one out MSB first.
 * Drives take to the buffer, shift_bit and frame_active to the pin driver.
 */

`timescale 1ns/100ps

module spi_frame_serializer (
    input  logic               clk,
    input  logic               nrst,
    input  logic               pending,
    input  tft_spi_pkg::word_t pend_address,
    input  tft_spi_pkg::word_t pend_data,
    output logic               take,
    output logic               shift_bit,
    output logic               frame_active,
    output logic               ack
);

    import tft_spi_pkg::*;

    spi_state_t state;
    spi_state_t next_state;

    // all frames of one write, first frame in the top bits
    logic [FRAME_BITS*FRAMES_PER_WRITE-1:0] interleaved;
    logic [FRAME_BITS*FRAMES_PER_WRITE-1:0] frame_store;

    // frame on the wire
    frame_t shift_reg;

    logic [3:0] bit_count;
    logic [1:0] frame_count;
    logic       last_bit;
    logic       last_frame;

    // address byte of rank idx next to data byte of the same rank
    function automatic frame_t pair_frame(
        input word_t       addr,
        input word_t       dat,
        input int unsigned idx
    );
        byte_t a_byte;
        byte_t d_byte;
        a_byte = addr[8*idx +: 8];
        d_byte = dat[8*idx +: 8];
        return {a_byte, d_byte};
    endfunction

    // rank 3 lands on top so it goes out first
    always_comb begin
        interleaved = '0;
        for (int i = 0; i < FRAMES_PER_WRITE; i++) begin
            interleaved[FRAME_BITS*i +: FRAME_BITS] = pair_frame(pend_address, pend_data, i);
        end
    end

    assign last_bit   = (bit_count == 4'(FRAME_BITS - 1));
    assign last_frame = (frame_count == 2'(FRAMES_PER_WRITE - 1));

    // state register
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // next state
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (pending) begin
                    next_state = LOAD;
                end
            end
            LOAD: begin
                next_state = SHIFT;
            end
            SHIFT: begin
                if (last_bit) begin
                    next_state = CS_HIGH;
                end
            end
            CS_HIGH: begin
                // one cycle gap, then next frame or finish
                next_state = last_frame ? DONE : SHIFT;
            end
            DONE: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // bit and frame counters
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            bit_count   <= '0;
            frame_count <= '0;
        end else begin
            case (state)
                LOAD: begin
                    bit_count   <= '0;
                    frame_count <= '0;
                end
                SHIFT: begin
                    // wraps back to zero after the last bit
                    bit_count <= bit_count + 4'd1;
                end
                CS_HIGH: begin
                    bit_count   <= '0;
                    frame_count <= frame_count + 2'd1;
                end
                default: begin
                    bit_count <= bit_count;
                end
            endcase
        end
    end

    // frame store and shift register
    always_ff @(posedge clk) begin
        case (state)
            LOAD: begin
                // own copy, buffer is free to refill from here on
                frame_store <= interleaved;
                shift_reg   <= interleaved[FRAME_BITS*FRAMES_PER_WRITE-1 -: FRAME_BITS];
            end
            SHIFT: begin
                shift_reg <= {shift_reg[FRAME_BITS-2:0], 1'b0};
            end
            CS_HIGH: begin
                // next frame sits just below the one just sent
                frame_store <= frame_store << FRAME_BITS;
                shift_reg   <= frame_store[FRAME_BITS*(FRAMES_PER_WRITE-1)-1 -: FRAME_BITS];
            end
            default: begin
                shift_reg <= shift_reg;
            end
        endcase
    end

    // outputs, decoded from state
    assign take         = (state == LOAD);
    assign frame_active = (state == SHIFT);
    assign ack          = (state == DONE);
    assign shift_bit    = frame_active & shift_reg[FRAME_BITS-1];

    // frame window is exactly one frame long
    a_frame_len : assert property (
        @(posedge clk) disable iff (!nrst)
        $rose(frame_active) |-> frame_active[*FRAME_BITS] ##1 !frame_active
    ) else $error("frame_active window not %0d cycles", FRAME_BITS);

    // single-cycle ack once all frames and gaps after LOAD are done
    a_ack_pulse : assert property (
        @(posedge clk) disable iff (!nrst)
        take |-> ##(FRAMES_PER_WRITE*(FRAME_BITS+1)+1) ack ##1 !ack
    ) else $error("ack not a one-cycle pulse at the end of the write");

endmodule

/* src/tft_pin_driver.sv */
/*
 * Display pin driver. Re-times serial data and chip select onto the
 * falling clock edge and gates clk into sclk only while a frame is open.
 */

`timescale 1ns/100ps

module tft_pin_driver (
    input  logic clk,
    input  logic nrst,
    input  logic shift_bit,
    input  logic frame_active,
    output logic bit_data,
    output logic chip_select,
    output logic sclk
);

    // bit_data as seen at the sclk rise
    logic sample_data;

    // launch on falling edge
    // half a cycle of setup before each sclk rise
    always_ff @(negedge clk or negedge nrst) begin
        if (!nrst) begin
            chip_select <= 1'b1;
            bit_data    <= 1'b0;
        end else begin
            // active low select
            chip_select <= !frame_active;
            bit_data    <= shift_bit;
        end
    end

    // gated serial clock
    // chip_select only moves while clk is low, so no runt pulses
    assign sclk = clk & !chip_select;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            sample_data <= 1'b0;
        end else begin
            sample_data <= bit_data;
        end
    end

    // data launched before the rise holds until clk falls again
    a_data_stable_high : assert property (
        @(negedge clk) disable iff (!nrst)
        !chip_select |-> bit_data == sample_data
    ) else $error("bit_data changed while sclk high");

endmodule

/* src/tft_spi_pkg.sv */
/*
 * Shared types and frame constants for the write-only TFT SPI link.
 * Import into module bodies; use scoped names in port lists.
 */

package tft_spi_pkg;

    // address or data word from the memory handler
    typedef logic [31:0] word_t;

    // one byte slice as it goes onto the wire
    typedef logic [7:0] byte_t;

    // serial frame, address byte high, data byte low
    typedef logic [15:0] frame_t;

    // bits shifted per chip select window
    localparam int FRAME_BITS = 16;

    // one frame per byte rank of the word pair
    localparam int FRAMES_PER_WRITE = 4;

    // serializer FSM
    // IDLE waits for a pending pair, LOAD copies it, SHIFT sends one frame,
    // CS_HIGH is the gap between frames, DONE raises ack
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        LOAD    = 3'd1,
        SHIFT   = 3'd2,
        CS_HIGH = 3'd3,
        DONE    = 3'd4
    } spi_state_t;

endpackage

/* src/tft_spi_top.sv */
/*
 * Top level of the TFT SPI link. Memory handler writes come in on wi,
 * address and data; ack returns per write; serial pins go to the display.
 */

`timescale 1ns/100ps

module tft_spi_top (
    input  logic               clk,
    input  logic               nrst,
    input  logic               wi,
    input  tft_spi_pkg::word_t address,
    input  tft_spi_pkg::word_t data,
    output logic               ack,
    output logic               bit_data,
    output logic               sclk,
    output logic               chip_select
);

    import tft_spi_pkg::*;

    // buffer to serializer
    logic  pending;
    word_t pend_address;
    word_t pend_data;

    // serializer to buffer
    logic take;

    // serializer to pin driver
    logic shift_bit;
    logic frame_active;

    // input side, one pair deep
    tft_write_buffer i_buffer (
        .clk          (clk),
        .nrst         (nrst),
        .wi           (wi),
        .address      (address),
        .data         (data),
        .take         (take),
        .pending      (pending),
        .pend_address (pend_address),
        .pend_data    (pend_data)
    );

    // frame FSM
    spi_frame_serializer i_serializer (
        .clk          (clk),
        .nrst         (nrst),
        .pending      (pending),
        .pend_address (pend_address),
        .pend_data    (pend_data),
        .take         (take),
        .shift_bit    (shift_bit),
        .frame_active (frame_active),
        .ack          (ack)
    );

    // output side, falling edge re-timing
    tft_pin_driver i_pin_driver (
        .clk          (clk),
        .nrst         (nrst),
        .shift_bit    (shift_bit),
        .frame_active (frame_active),
        .bit_data     (bit_data),
        .chip_select  (chip_select),
        .sclk         (sclk)
    );

endmodule

/* src/tft_write_buffer.sv */
/*
 * One-deep write buffer between the memory handler and the serializer.
 * Holds an address/data pair from wi until the serializer pulses take.
 */

`timescale 1ns/100ps

module tft_write_buffer (
    input  logic               clk,
    input  logic               nrst,
    input  logic               wi,
    input  tft_spi_pkg::word_t address,
    input  tft_spi_pkg::word_t data,
    input  logic               take,
    output logic               pending,
    output tft_spi_pkg::word_t pend_address,
    output tft_spi_pkg::word_t pend_data
);

    // write is accepted when the slot is free or being emptied now
    logic accept;

    assign accept = wi && (!pending || take);

    // pending flag
    // refill wins over take, so a same-cycle wi keeps it high
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pending <= 1'b0;
        end else begin
            if (accept) begin
                pending <= 1'b1;
            end else if (take) begin
                pending <= 1'b0;
            end
        end
    end

    // stored pair
    // only overwritten by an accepted write, a dropped wi leaves it alone
    always_ff @(posedge clk) begin
        if (accept) begin
            pend_address <= address;
            pend_data    <= data;
        end
    end

    // memory handler must not write into a full slot,
    // unless the serializer is taking the old pair this cycle
    a_no_overrun : assert property (
        @(posedge clk) disable iff (!nrst)
        wi |-> (!pending || take)
    ) else $error("write buffer overrun, wi while pending without take");

    // serializer only takes what is actually there
    a_take_when_pending : assert property (
        @(posedge clk) disable iff (!nrst)
        take |-> pending
    ) else $error("take pulsed with empty write buffer");

endmodule

/* testbench/tb_spi_capture.sv */
/*
 * Receive side of the display for the testbench. Shifts bit_data in on
 * sclk rising edges while chip_select is low and queues each whole frame.
 */

`timescale 1ns/100ps

module tb_spi_capture (
    input  logic sclk,
    input  logic chip_select,
    input  logic bit_data,
    output int   bad_frames
);

    import tft_spi_pkg::*;

    // completed frames, oldest first, popped by the testbench
    frame_t frames[$];

    frame_t shift_in;
    int     edge_count;
    logic   in_frame;

    initial begin
        bad_frames = 0;
        edge_count = 0;
        in_frame   = 1'b0;
        shift_in   = '0;
    end

    // select falls, a new frame opens
    always @(negedge chip_select) begin
        in_frame   = 1'b1;
        edge_count = 0;
        shift_in   = '0;
    end

    // msb first, so each new bit enters at the bottom
    always @(posedge sclk) begin
        if (chip_select === 1'b0) begin
            shift_in   = {shift_in[FRAME_BITS-2:0], bit_data};
            edge_count = edge_count + 1;
        end
    end

    // select rises, frame is complete
    // the reset rise from x is skipped since no frame was open
    always @(posedge chip_select) begin
        if (in_frame) begin
            if (edge_count != FRAME_BITS) begin
                $display("frame shape error at %0t ns: frame had %0d sclk rising edges, not %0d",
                         $time, edge_count, FRAME_BITS);
                bad_frames = bad_frames + 1;
            end
            frames.push_back(shift_in);
            in_frame = 1'b0;
        end
    end

endmodule

/* testbench/tb_tft_spi_top.sv */
/*
 * Directed testbench for the TFT SPI link. Drives memory handler writes,
 * checks the serial frames collected by the capture model and the ack pulses.
 */

`timescale 1ns/100ps

module tb_tft_spi_top;

    import tft_spi_pkg::*;

    // one write is about 72 cycles on an idle wire
    localparam int ACK_TIMEOUT = 200;
    localparam int CS_TIMEOUT  = 20;

    logic  clk;
    logic  nrst;
    logic  wi;
    word_t address;
    word_t data;
    logic  ack;
    logic  bit_data;
    logic  sclk;
    logic  chip_select;

    int          bad_frames;
    int          ack_count;
    int          errors;
    int          tests_run;

    tft_spi_top i_dut (
        .clk         (clk),
        .nrst        (nrst),
        .wi          (wi),
        .address     (address),
        .data        (data),
        .ack         (ack),
        .bit_data    (bit_data),
        .sclk        (sclk),
        .chip_select (chip_select)
    );

    tb_spi_capture i_capture (
        .sclk        (sclk),
        .chip_select (chip_select),
        .bit_data    (bit_data),
        .bad_frames  (bad_frames)
    );

    always #50 clk = ~clk;

    // ack is a one-cycle pulse, stable around the falling edge
    always @(negedge clk) begin
        if (nrst && ack === 1'b1) begin
            ack_count = ack_count + 1;
        end
    end

    // frame k of a write, k = 0 goes out first with the top bytes
    function automatic frame_t expected_frame(input word_t addr, input word_t dat, input int k);
        int    rank;
        byte_t a_byte;
        byte_t d_byte;
        rank   = FRAMES_PER_WRITE - 1 - k;
        a_byte = byte_t'(addr >> (8 * rank));
        d_byte = byte_t'(dat >> (8 * rank));
        return {a_byte, d_byte};
    endfunction

    task automatic finish_run();
        $display("summary: %0d tests run, %0d failed checks, %0d bad frames",
                 tests_run, errors, bad_frames);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic abort_run(input string reason);
        $display("run stopped at %0t ns: %s", $time, reason);
        errors = errors + 1;
        finish_run();
    endtask

    // one-cycle wi pulse, driven on the falling edge
    task automatic write_pair(input word_t addr, input word_t dat);
        @(negedge clk);
        wi      = 1'b1;
        address = addr;
        data    = dat;
        @(negedge clk);
        wi      = 1'b0;
    endtask

    task automatic wait_acks(input int target);
        int cycles;
        cycles = 0;
        while (ack_count < target && cycles < ACK_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (ack_count < target) abort_run("ack never came back from the DUT");
    endtask

    // pops four frames and compares them with the interleave rule
    task automatic check_frames(input word_t addr, input word_t dat);
        frame_t got;
        frame_t exp;
        for (int k = 0; k < FRAMES_PER_WRITE; k++) begin
            exp = expected_frame(addr, dat, k);
            assert (i_capture.frames.size() > 0) else begin
                $display("frame %0d of write %h/%h never arrived", k, addr, dat);
                errors++;
            end
            if (i_capture.frames.size() > 0) begin
                got = i_capture.frames.pop_front();
                assert (got == exp) else begin
                    $display("[ERROR] %0t ns: frame %0d of write %h/%h is %h, expected %h",
                             $time, k, addr, dat, got, exp);
                    errors++;
                end
            end
        end
    endtask

    // common tail: ack count, no stray frames, frame shape, one report line
    task automatic end_test(input string name, input int acks, input int err0, input int shape0);
        repeat (5) @(posedge clk);
        assert (ack_count == acks) else begin
            $display("[ERROR] %0t ns: %0d ack pulses, expected %0d", $time, ack_count, acks);
            errors++;
        end
        assert (i_capture.frames.size() == 0) else begin
            $display("%0d extra frames seen on the wire", i_capture.frames.size());
            errors++;
        end
        assert (bad_frames == shape0) else begin
            $display("frames with a wrong sclk edge count during %s", name);
            errors++;
        end
        tests_run++;
        $display("%s: finished with %0d failed checks", name, errors - err0);
    endtask

    task automatic test_reset_state();
        int err0;
        err0 = errors;
        // idle pins checked in both clock phases
        repeat (4) begin
            @(negedge clk);
            #20;
            assert (chip_select === 1'b1 && sclk === 1'b0 && ack === 1'b0 && bit_data === 1'b0)
            else begin
                $display("[ERROR] %0t ns: idle pins cs=%b sclk=%b ack=%b data=%b",
                         $time, chip_select, sclk, ack, bit_data);
                errors++;
            end
            @(posedge clk);
            #20;
            assert (chip_select === 1'b1 && sclk === 1'b0) else begin
                $display("[ERROR] %0t ns: sclk=%b with cs=%b", $time, sclk, chip_select);
                errors++;
            end
        end
        end_test("reset_state", 0, err0, bad_frames);
    endtask

    task automatic test_single_write();
        int acks0;
        int err0;
        int shape0;
        acks0  = ack_count;
        err0   = errors;
        shape0 = bad_frames;
        write_pair(32'ha1b2_c3d4, 32'h1122_3344);
        wait_acks(acks0 + 1);
        check_frames(32'ha1b2_c3d4, 32'h1122_3344);
        end_test("single_write", acks0 + 1, err0, shape0);
    endtask

    task automatic test_random_writes();
        word_t addr;
        word_t dat;
        int    acks0;
        int    err0;
        int    shape0;
        acks0  = ack_count;
        err0   = errors;
        shape0 = bad_frames;
        for (int n = 0; n < 20; n++) begin
            addr = $urandom;
            dat  = $urandom;
            write_pair(addr, dat);
            wait_acks(acks0 + n + 1);
            check_frames(addr, dat);
        end
        end_test("random_writes", acks0 + 20, err0, shape0);
    endtask

    task automatic test_back_to_back();
        int cycles;
        int acks0;
        int err0;
        int shape0;
        acks0  = ack_count;
        err0   = errors;
        shape0 = bad_frames;
        cycles = 0;
        write_pair(32'hdead_beef, 32'h0f1e_2d3c);
        // first pair is in the serializer once select drops
        while (chip_select !== 1'b0 && cycles < CS_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (chip_select !== 1'b0) abort_run("chip_select never went low for the first write");
        write_pair(32'h5a69_7887, 32'hc3b4_a596);
        wait_acks(acks0 + 2);
        check_frames(32'hdead_beef, 32'h0f1e_2d3c);
        check_frames(32'h5a69_7887, 32'hc3b4_a596);
        end_test("back_to_back", acks0 + 2, err0, shape0);
    endtask

    initial begin
        clk        = 1'b0;
        nrst       = 1'b0;
        wi         = 1'b0;
        address    = '0;
        data       = '0;
        errors     = 0;
        tests_run  = 0;
        ack_count  = 0;
        void'($urandom(32'h0b8b_d5b1));
        repeat (2) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;
        test_reset_state();
        test_single_write();
        test_random_writes();
        test_back_to_back();
        finish_run();
    end

endmodule
